//--- flist.f
+incdir+tb
hdl/loader_pkg.sv
hdl/prg_load_fsm.sv
hdl/basic_ptr_table.sv
hdl/mem_write_port.sv
hdl/keystroke_timer.sv
hdl/autorun_keys.sv
hdl/c64_loader_top.sv
tb/loader_properties.sv
tb/tb_c64_loader.sv

//--- tb/loader_tests.svh
//====================
// Directed loader tests
// Reset, download with pointer fill, autorun on and off
//====================
`ifndef LOADER_TESTS_SVH
`define LOADER_TESTS_SVH

	// One file byte offered only while the loader is not holding off
	task automatic send_byte(input c64_addr_t offset, input byte_t data);
		@(posedge clk_sys);
		while (ioctl_wait_o)
			@(posedge clk_sys);
		ioctl_wr_i   <= 1'b1;
		ioctl_addr_i <= offset;
		ioctl_data_i <= data;
		@(posedge clk_sys);
		ioctl_wr_i <= 1'b0;
	endtask

	task automatic reset_values();
		@(posedge clk_sys);
		check_bit("mem_we_o", mem_we_o, 1'b0);
		check_bit("ioctl_wait_o", ioctl_wait_o, 1'b0);
		check_key("key_o", key_o, '0);
	endtask

	// Full PRG download followed by checks of the data and pointer writes
	task automatic run_download(input logic autorun);
		int        i;
		c64_addr_t load_addr;
		c64_addr_t end_addr;
		byte_t     lo;
		byte_t     hi;
		c64_addr_t ptr_addr [PTR_COUNT];
		byte_t     ptr_val [PTR_COUNT];
		load_addr = {file_bytes[1], file_bytes[0]};
		end_addr  = load_addr + 16'(DATA_LEN);
		lo        = end_addr[7:0];
		hi        = end_addr[15:8];
		// Zero-page targets in the order a BASIC LOAD leaves them
		ptr_addr = '{16'h002B, 16'h002C, 16'h00AC, 16'h00AD, 16'h002D, 16'h002F,
			16'h0031, 16'h00AE, 16'h002E, 16'h0030, 16'h0032, 16'h00AF};
		ptr_val  = '{8'h01, 8'h08, 8'h00, 8'h00, lo, lo, lo, lo, hi, hi, hi, hi};
		@(posedge clk_sys);
		autorun_en_i <= autorun;
		wr_addr_q.delete();
		wr_data_q.delete();
		ioctl_download_i <= 1'b1;
		repeat (2) @(posedge clk_sys);
		for (i = 0; i < FILE_LEN; i++)
			send_byte(c64_addr_t'(i), file_bytes[i]);
		@(posedge clk_sys);
		while (ioctl_wait_o)
			@(posedge clk_sys);
		// Key words typed after this load start from an empty log
		key_log_q.delete();
		key_cycle_q.delete();
		ioctl_download_i <= 1'b0;
		while (wr_addr_q.size() < DATA_LEN + PTR_COUNT)
			@(posedge clk_sys);
		repeat (10) @(posedge clk_sys);
		if (wr_addr_q.size() != DATA_LEN + PTR_COUNT)
			abort_run($sformatf("Expected %0d memory writes but saw %0d",
				DATA_LEN + PTR_COUNT, wr_addr_q.size()));
		for (i = 0; i < DATA_LEN; i++) begin
			check_addr("mem_addr_o", wr_addr_q[i], load_addr + c64_addr_t'(i));
			check_byte("mem_data_o", wr_data_q[i], file_bytes[i + 2]);
		end
		for (i = 0; i < PTR_COUNT; i++) begin
			check_addr("mem_addr_o", wr_addr_q[DATA_LEN + i], ptr_addr[i]);
			check_byte("mem_data_o", wr_data_q[DATA_LEN + i], ptr_val[i]);
		end
	endtask

	// Press and release words for R, U, N and RETURN spaced KEY_GAP cycles apart
	task automatic autorun_typing();
		byte_t letters [4];
		int    i;
		logic  strobe;
		letters = '{SCAN_R, SCAN_U, SCAN_N, SCAN_RETURN};
		strobe  = KEY_IDLE[10];
		while (key_log_q.size() < KEY_STEPS + 1)
			@(posedge clk_sys);
		for (i = 0; i < KEY_STEPS; i++) begin
			strobe = ~strobe;
			check_key("key_o", key_log_q[i], {strobe, (i % 2 == 0), 1'b0, letters[i / 2]});
			if (i > 0 && key_cycle_q[i] - key_cycle_q[i - 1] != KEY_GAP)
				abort_run($sformatf("Typed words %0d and %0d are not %0d cycles apart",
					i - 1, i, KEY_GAP));
		end
		// The live keyboard word is back once typing ends
		check_key("key_o", key_log_q[KEY_STEPS], KEY_IDLE);
	endtask

	// Live keyboard stays connected through a whole load without autorun
	task automatic autorun_off();
		track_keys <= 1'b1;
		run_download(1'b0);
		repeat (3 * KEY_GAP) @(posedge clk_sys);
		track_keys <= 1'b0;
		@(posedge clk_sys);
	endtask

`endif

//--- tb/tb_c64_loader.sv
//====================
// Program loader testbench
// Drives PRG downloads and keyboard traffic into the loader,
// checks memory writes, pointer fill and typed key words
//====================
`timescale 1ns/1ns

module tb_c64_loader;
	import loader_pkg::*;

	localparam int unsigned KEY_GAP  = 20;
	localparam int          FILE_LEN = 12;
	localparam int          DATA_LEN = FILE_LEN - 2;
	localparam ps2_word_t   KEY_IDLE = 11'h1A5;
	// Two downloads at slow slot rates plus one autorun sequence and some margin
	localparam int MAX_CYCLES = 2 * (FILE_LEN + PTR_COUNT) * 64 + 4 * KEY_STEPS * KEY_GAP + 200;

	logic      clk_sys;
	logic      RESET            = 1'b1;
	logic      ioctl_download_i = 1'b0;
	logic      ioctl_wr_i       = 1'b0;
	c64_addr_t ioctl_addr_i     = '0;
	byte_t     ioctl_data_i     = '0;
	logic      io_slot_i        = 1'b0;
	logic      autorun_en_i     = 1'b0;
	ps2_word_t ps2_key_i        = KEY_IDLE;
	logic      ioctl_wait_o;
	logic      mem_we_o;
	c64_addr_t mem_addr_o;
	byte_t     mem_data_o;
	ps2_word_t key_o;

	c64_addr_t wr_addr_q[$];
	byte_t     wr_data_q[$];
	ps2_word_t key_log_q[$];
	int        key_cycle_q[$];
	byte_t     file_bytes[FILE_LEN];
	integer    seed        = 32'h2ec77905;
	int        cycle_cnt   = 0;
	logic      track_keys  = 1'b0;
	logic      track_valid = 1'b0;
	ps2_word_t key_prev;
	ps2_word_t ps2_prev;

	c64_loader_top #(.KEY_GAP(KEY_GAP)) dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	//====================
	// Result checks
	//====================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "Run stopped at %0t", $time);
	endtask

	task automatic check_addr(input string name, input c64_addr_t got, input c64_addr_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL at %0t: %s = %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL at %0t: %s = %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_key(input string name, input ps2_word_t got, input ps2_word_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL at %0t: %s = %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("FAIL at %0t: %s = %b, expected %b", $time, name, got, exp));
	endtask

	`include "loader_tests.svh"

	//====================
	// Monitors
	//====================
	always @(posedge clk_sys) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
			abort_run($sformatf("Timeout after %0d cycles, the loader stopped responding",
				cycle_cnt));
		if (mem_we_o) begin
			wr_addr_q.push_back(mem_addr_o);
			wr_data_q.push_back(mem_data_o);
		end
		if (key_o !== key_prev) begin
			key_log_q.push_back(key_o);
			key_cycle_q.push_back(cycle_cnt);
		end
		key_prev = key_o;
		// Passthrough keeps key_o one cycle behind the live word
		if (track_keys && track_valid)
			check_key("key_o", key_o, ps2_prev);
		track_valid = track_keys;
		ps2_prev    = ps2_key_i;
		ps2_key_i  <= track_keys ? ps2_key_i + 11'd37 : KEY_IDLE;
	end

	// Random one-cycle slot grants about one cycle in four, sometimes back to back
	initial begin
		repeat (8) @(posedge clk_sys);
		forever begin
			@(posedge clk_sys);
			io_slot_i <= (($random(seed) & 3) == 0);
		end
	end

	initial begin
		int i;
		file_bytes[0] = 8'h01;
		file_bytes[1] = 8'h08;
		for (i = 2; i < FILE_LEN; i++)
			file_bytes[i] = $random(seed);
		repeat (5) @(posedge clk_sys);
		RESET <= 1'b0;
		reset_values();
		run_download(1'b1);
		autorun_typing();
		autorun_off();
		if (dut_i.u_props.assert_fails == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- tb/loader_properties.sv
//====================
// Loader handshake properties
// Bound to the loader top level
//====================
`timescale 1ns/1ns

module loader_properties (
	input logic clk_sys,
	input logic RESET,
	input logic host_wr_i,
	input logic host_wait_i,
	input logic slot_i,
	input logic mem_we_i
);

	int unsigned assert_fails = 0;

	// A pending byte is written once, then the port is free again
	we_single_cycle: assert property (@(posedge clk_sys) disable iff (RESET)
		mem_we_i |=> !mem_we_i)
		else begin
			assert_fails++;
			$error("mem_we_o high for two cycles in a row");
		end

	host_respects_wait: assert property (@(posedge clk_sys) disable iff (RESET)
		host_wr_i |-> !host_wait_i)
		else begin
			assert_fails++;
			$error("ioctl_wr_i arrived while ioctl_wait_o was high");
		end

	we_needs_slot: assert property (@(posedge clk_sys) disable iff (RESET)
		mem_we_i |-> slot_i)
		else begin
			assert_fails++;
			$error("mem_we_o without an I/O slot");
		end

endmodule

bind c64_loader_top loader_properties u_props (
	.clk_sys     (clk_sys),
	.RESET       (RESET),
	.host_wr_i   (ioctl_wr_i),
	.host_wait_i (ioctl_wait_o),
	.slot_i      (io_slot_i),
	.mem_we_i    (mem_we_o)
);

//--- hdl/c64_loader_top.sv
//====================
// C64 program loader
// PRG download, BASIC pointer injection and autorun typing
//====================
`timescale 1ns/1ns

module c64_loader_top
	import loader_pkg::*;
#(
	parameter int unsigned KEY_GAP = 1280000
)
(
	input  logic      clk_sys,
	input  logic      RESET,
	input  logic      ioctl_download_i,
	input  logic      ioctl_wr_i,
	input  c64_addr_t ioctl_addr_i,
	input  byte_t     ioctl_data_i,
	input  logic      io_slot_i,
	input  logic      autorun_en_i,
	input  ps2_word_t ps2_key_i,
	output logic      ioctl_wait_o,
	output logic      mem_we_o,
	output c64_addr_t mem_addr_o,
	output byte_t     mem_data_o,
	output ps2_word_t key_o
);

	wr_cmd_e              wr_cmd;
	logic [PTR_IDX_W-1:0] ptr_idx;
	c64_addr_t            end_addr;
	c64_addr_t            ptr_addr;
	byte_t                ptr_val;
	logic                 autorun_active;
	logic                 tick;
	logic [3:0]           step;
	logic                 done;

	//====================
	// Download and pointer fill
	//====================
	prg_load_fsm u_fsm (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.autorun_en_i     (autorun_en_i),
		.pending_i        (ioctl_wait_o),
		.done_i           (done),
		.ioctl_addr_i     (ioctl_addr_i),
		.wr_cmd_o         (wr_cmd),
		.ptr_idx_o        (ptr_idx),
		.autorun_active_o (autorun_active)
	);

	// A pending byte is also the host back-pressure
	mem_write_port u_wr_port (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.io_slot_i  (io_slot_i),
		.wr_cmd_i   (wr_cmd),
		.byte_i     (ioctl_data_i),
		.ptr_addr_i (ptr_addr),
		.ptr_val_i  (ptr_val),
		.pending_o  (ioctl_wait_o),
		.end_addr_o (end_addr),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

	basic_ptr_table u_ptr_table (
		.ptr_idx_i  (ptr_idx),
		.end_addr_i (end_addr),
		.ptr_addr_o (ptr_addr),
		.ptr_val_o  (ptr_val)
	);

	//====================
	// Autorun keyboard path
	//====================
	keystroke_timer #(
		.KEY_GAP (KEY_GAP)
	) u_key_timer (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.en_i    (autorun_active),
		.tick_o  (tick),
		.step_o  (step),
		.done_o  (done)
	);

	autorun_keys u_keys (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.active_i  (autorun_active),
		.tick_i    (tick),
		.step_i    (step),
		.ps2_key_i (ps2_key_i),
		.key_o     (key_o)
	);

endmodule

//--- hdl/autorun_keys.sv
//====================
// Autorun key generator
// Types R, U, N, RETURN or passes the live keyboard through
//====================
`timescale 1ns/1ns

module autorun_keys
	import loader_pkg::*;
(
	input  logic       clk_sys,
	input  logic       RESET,
	input  logic       active_i,
	input  logic       tick_i,
	input  logic [3:0] step_i,
	input  ps2_word_t  ps2_key_i,
	output ps2_word_t  key_o
);

	logic [3:0] letter_idx;
	byte_t      scan;
	ps2_word_t  key_q;

	// Steps pair up as press and release of one letter
	assign letter_idx = (step_i + 4'd1) >> 1;

	always_comb begin
		case (letter_idx)
			4'd1:    scan = SCAN_R;
			4'd2:    scan = SCAN_U;
			4'd3:    scan = SCAN_N;
			4'd4:    scan = SCAN_RETURN;
			default: scan = 8'h00;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			key_q <= '0;
		end
		else if (active_i) begin
			// New word per tick, strobe flips so the core sees it
			if (tick_i)
				key_q <= {~key_q[10], step_i[0], 1'b0, scan};
		end
		else begin
			key_q <= ps2_key_i;
		end
	end

	assign key_o = key_q;

endmodule

//--- hdl/keystroke_timer.sv
//====================
// Autorun keystroke timer
// Ticks every KEY_GAP cycles and numbers the typed words
//====================
`timescale 1ns/1ns

module keystroke_timer
	import loader_pkg::*;
#(
	parameter int unsigned KEY_GAP = 1280000
)
(
	input  logic       clk_sys,
	input  logic       RESET,
	input  logic       en_i,
	output logic       tick_o,
	output logic [3:0] step_o,
	output logic       done_o
);

	localparam int CNT_W = (KEY_GAP > 1) ? $clog2(KEY_GAP) : 1;

	logic [CNT_W-1:0] gap_cnt_q;
	logic [3:0]       step_q;

	assign tick_o = en_i && (gap_cnt_q == CNT_W'(KEY_GAP - 1));

	// Step number carried by the coming tick, 1 for the first
	assign step_o = step_q + 4'd1;
	assign done_o = tick_o && (step_o == 4'(KEY_STEPS));

	always_ff @(posedge clk_sys) begin
		if (RESET || !en_i) begin
			gap_cnt_q <= '0;
			step_q    <= 4'd0;
		end
		else if (tick_o) begin
			gap_cnt_q <= '0;
			step_q    <= step_o;
		end
		else begin
			gap_cnt_q <= gap_cnt_q + 1'b1;
		end
	end

endmodule

//--- hdl/mem_write_port.sv
//====================
// Memory write port
// Load address counter and one pending byte, written at an I/O slot
//====================
`timescale 1ns/1ns

module mem_write_port
	import loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      RESET,
	input  logic      io_slot_i,
	input  wr_cmd_e   wr_cmd_i,
	input  byte_t     byte_i,
	input  c64_addr_t ptr_addr_i,
	input  byte_t     ptr_val_i,
	output logic      pending_o,
	output c64_addr_t end_addr_o,
	output logic      mem_we_o,
	output c64_addr_t mem_addr_o,
	output byte_t     mem_data_o
);

	c64_addr_t load_addr_q;
	logic      pending_q;
	c64_addr_t pend_addr_q;
	byte_t     pend_data_q;

	// Control state
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			load_addr_q <= 16'h0000;
			pending_q   <= 1'b0;
		end
		else begin
			case (wr_cmd_i)
				WR_SET_LO: load_addr_q[7:0]  <= byte_i;
				WR_SET_HI: load_addr_q[15:8] <= byte_i;
				WR_DATA: begin
					load_addr_q <= load_addr_q + 16'd1;
					pending_q   <= 1'b1;
				end
				WR_PTR: pending_q <= 1'b1;
				default: begin
					if (mem_we_o)
						pending_q <= 1'b0;
				end
			endcase
		end
	end

	// Pending payload
	always_ff @(posedge clk_sys) begin
		if (wr_cmd_i == WR_DATA) begin
			pend_addr_q <= load_addr_q;
			pend_data_q <= byte_i;
		end
		else if (wr_cmd_i == WR_PTR) begin
			pend_addr_q <= ptr_addr_i;
			pend_data_q <= ptr_val_i;
		end
	end

	// The first granted slot takes the pending byte
	assign mem_we_o   = pending_q & io_slot_i;
	assign mem_addr_o = pend_addr_q;
	assign mem_data_o = pend_data_q;

	assign pending_o  = pending_q;
	assign end_addr_o = load_addr_q;

endmodule

//--- hdl/basic_ptr_table.sv
//====================
// BASIC pointer table
// Zero-page target and value for each injected pointer byte
//====================
`timescale 1ns/1ns

module basic_ptr_table
	import loader_pkg::*;
(
	input  logic [PTR_IDX_W-1:0] ptr_idx_i,
	input  c64_addr_t            end_addr_i,
	output c64_addr_t            ptr_addr_o,
	output byte_t                ptr_val_o
);

	always_comb begin
		ptr_addr_o = 16'h0000;
		ptr_val_o  = 8'h00;
		case (ptr_idx_i)
			// TXT start stays at $0801, SAVE start stays zero
			4'd0:  begin ptr_addr_o = 16'h002B; ptr_val_o = 8'h01; end
			4'd1:  begin ptr_addr_o = 16'h002C; ptr_val_o = 8'h08; end
			4'd2:  begin ptr_addr_o = 16'h00AC; ptr_val_o = 8'h00; end
			4'd3:  begin ptr_addr_o = 16'h00AD; ptr_val_o = 8'h00; end
			// VAR, ARY, STR and LOAD_END all point past the program
			4'd4:  begin ptr_addr_o = 16'h002D; ptr_val_o = end_addr_i[7:0]; end
			4'd5:  begin ptr_addr_o = 16'h002F; ptr_val_o = end_addr_i[7:0]; end
			4'd6:  begin ptr_addr_o = 16'h0031; ptr_val_o = end_addr_i[7:0]; end
			4'd7:  begin ptr_addr_o = 16'h00AE; ptr_val_o = end_addr_i[7:0]; end
			4'd8:  begin ptr_addr_o = 16'h002E; ptr_val_o = end_addr_i[15:8]; end
			4'd9:  begin ptr_addr_o = 16'h0030; ptr_val_o = end_addr_i[15:8]; end
			4'd10: begin ptr_addr_o = 16'h0032; ptr_val_o = end_addr_i[15:8]; end
			4'd11: begin ptr_addr_o = 16'h00AF; ptr_val_o = end_addr_i[15:8]; end
			default: begin
				ptr_addr_o = 16'h0000;
				ptr_val_o  = 8'h00;
			end
		endcase
	end

endmodule

//--- hdl/prg_load_fsm.sv
//====================
// PRG load sequencer
// Classifies download bytes, then walks the BASIC pointer table
// and hands over to autorun typing
//====================
`timescale 1ns/1ns

module prg_load_fsm
	import loader_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 ioctl_download_i,
	input  logic                 ioctl_wr_i,
	input  logic                 autorun_en_i,
	input  logic                 pending_i,
	input  logic                 done_i,
	input  c64_addr_t            ioctl_addr_i,
	output wr_cmd_e              wr_cmd_o,
	output logic [PTR_IDX_W-1:0] ptr_idx_o,
	output logic                 autorun_active_o
);

	localparam logic [PTR_IDX_W-1:0] LAST_IDX = PTR_IDX_W'(PTR_COUNT - 1);

	load_state_e          state_q;
	logic                 dl_q;
	logic                 dl_rise;
	logic                 dl_fall;
	logic                 in_file;
	logic [PTR_IDX_W-1:0] ptr_idx_q;

	assign dl_rise = ioctl_download_i & ~dl_q;
	assign dl_fall = ~ioctl_download_i & dl_q;
	assign in_file = (state_q == ST_HEADER) || (state_q == ST_DATA);

	// Offsets 0 and 1 carry the little-endian load address
	always_comb begin
		wr_cmd_o = WR_NONE;
		if (in_file && ioctl_wr_i) begin
			if (ioctl_addr_i == 16'd0)
				wr_cmd_o = WR_SET_LO;
			else if (ioctl_addr_i == 16'd1)
				wr_cmd_o = WR_SET_HI;
			else
				wr_cmd_o = WR_DATA;
		end
		else if (state_q == ST_PTR_FILL && !pending_i) begin
			wr_cmd_o = WR_PTR;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state_q   <= ST_IDLE;
			dl_q      <= 1'b0;
			ptr_idx_q <= '0;
		end
		else begin
			dl_q <= ioctl_download_i;
			case (state_q)
				ST_IDLE: begin
					if (dl_rise)
						state_q <= ST_HEADER;
				end
				ST_HEADER, ST_DATA: begin
					if (dl_fall) begin
						state_q   <= ST_PTR_FILL;
						ptr_idx_q <= '0;
					end
					else if (ioctl_wr_i && ioctl_addr_i == 16'd1) begin
						state_q <= ST_DATA;
					end
				end
				ST_PTR_FILL: begin
					// One pointer byte per free write slot
					if (!pending_i) begin
						if (ptr_idx_q == LAST_IDX) begin
							ptr_idx_q <= '0;
							state_q   <= autorun_en_i ? ST_AUTORUN : ST_IDLE;
						end
						else begin
							ptr_idx_q <= ptr_idx_q + 1'b1;
						end
					end
				end
				ST_AUTORUN: begin
					if (done_i)
						state_q <= ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	assign ptr_idx_o        = ptr_idx_q;
	assign autorun_active_o = (state_q == ST_AUTORUN);

endmodule

//--- hdl/loader_pkg.sv
//====================
// Program loader shared definitions
// C64 address and byte types, sequencer states, write-port opcodes,
// BASIC pointer table sizing and autorun key codes
//====================

package loader_pkg;

	typedef logic [15:0] c64_addr_t;
	typedef logic [7:0]  byte_t;

	// PS/2 word: [10] strobe toggle, [9] pressed, [7:0] scan code
	typedef logic [10:0] ps2_word_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_HEADER,
		ST_DATA,
		ST_PTR_FILL,
		ST_AUTORUN
	} load_state_e;

	typedef enum logic [2:0] {
		WR_NONE,
		WR_SET_LO,
		WR_SET_HI,
		WR_DATA,
		WR_PTR
	} wr_cmd_e;

	//====================
	// BASIC pointer injection
	//====================
	localparam int PTR_COUNT = 12;
	localparam int PTR_IDX_W = 4;

	//====================
	// Autorun typing
	//====================
	// R, U, N, RETURN as press and release pairs
	localparam int KEY_STEPS = 8;

	localparam byte_t SCAN_R      = 8'h2D;
	localparam byte_t SCAN_U      = 8'h3C;
	localparam byte_t SCAN_N      = 8'h31;
	localparam byte_t SCAN_RETURN = 8'h5A;

endpackage
